// ==== filelist.f ====
+incdir+common
common/regfile_pkg.sv
regfile/rv_regfile.sv
verilog/dbg_wait_timer.sv
verilog/dbg_apb_fsm.sv
verilog/regfile_subsys_top.sv
test/tb_clkgen.sv
test/regfile_subsys_checker.sv
test/regfile_subsys_tb.sv

// ==== test/regfile_subsys_tb.sv ====
/*
 * Register file subsystem testbench
 * Directed tests of core ports, APB debug access, write arbitration and status pins
 */

`timescale 1ns/1ns

`include "regfile_params.svh"

module regfile_subsys_tb;

    import regfile_pkg::*;

    localparam int APB_TIMEOUT = 2 * `DBG_WAIT_LIMIT + 4;

    logic        clk;
    logic        rst_n;
    reg_wr_req_t wb_req;
    reg_addr_t   rd1_addr;
    reg_addr_t   rd2_addr;
    cpu_word_t   rd1_data;
    cpu_word_t   rd2_data;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [1:0]  status;

    // Expected register contents
    cpu_word_t   shadow [`REG_NUM];
    logic [31:0] lfsr_state  = 32'haa38_2247;
    int          error_count = 0;

    tb_clkgen tb_clkgen_i (.clk_o(clk), .rst_n_o(rst_n));

    regfile_subsys_top regfile_subsys_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req_i   (wb_req),
        .rd1_addr_i (rd1_addr),
        .rd1_data_o (rd1_data),
        .rd2_addr_i (rd2_addr),
        .rd2_data_o (rd2_data),
        .apb_req_i  (apb_req),
        .apb_rsp_o  (apb_rsp),
        .status_o   (status)
    );

    // --------------------
    // Random data
    // --------------------
    // Galois LFSR stepped once per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic cpu_word_t random_bits(input int width);
        cpu_word_t value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    // Registers 1 to 31
    function automatic reg_addr_t random_reg();
        return reg_addr_t'(1 + (random_bits(5) % 31));
    endfunction

    // --------------------
    // Checking
    // --------------------
    task automatic abort_run(input string line);
        error_count++;
        $display("%s", line);
        $display("Errors found");
        $fatal(1, "Simulation aborted");
    endtask

    task automatic check_value(input cpu_word_t actual, input cpu_word_t expected,
                               input string msg);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %0t ns: %s: got %h, expected %h",
                                $time, msg, actual, expected));
        end
    endtask

    task automatic check_status();
        check_value(cpu_word_t'(status), cpu_word_t'({shadow[27][0], shadow[26][0]}),
                    "status_o");
    endtask

    // Bound checker failures end the run at once
    always @(negedge clk) begin
        if (regfile_subsys_top_i.regfile_subsys_checker_i.fail_count != 0) begin
            abort_run("An assertion in the bound checker failed");
        end
    end

    // --------------------
    // Bus tasks entered and left on a falling edge
    // --------------------
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input cpu_word_t wdata,
                                output cpu_word_t rdata, output logic err);
        int waited;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        waited = 0;
        @(posedge clk);
        while (!apb_rsp.pready) begin
            waited++;
            if (waited > APB_TIMEOUT) begin
                abort_run("APB transfer timed out waiting for PREADY");
            end
            @(posedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input cpu_word_t data, output logic err);
        cpu_word_t ignored_rdata;
        apb_transfer(1'b1, addr, data, ignored_rdata, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output cpu_word_t data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic debug_write_ok(input reg_addr_t r, input cpu_word_t data);
        logic err;
        apb_write(apb_addr_t'({r, 2'b00}), data, err);
        check_value(cpu_word_t'(err), '0, "PSLVERR on debug write");
        if (r != '0) begin
            shadow[r] = data;
        end
    endtask

    task automatic core_write(input reg_addr_t r, input cpu_word_t data);
        wb_req = '{en: 1'b1, addr: r, data: data};
        @(negedge clk);
        wb_req.en = 1'b0;
        if (r != '0) begin
            shadow[r] = data;
        end
    endtask

    task automatic core_read_check(input reg_addr_t r);
        cpu_word_t expected;
        expected = (r == '0) ? '0 : shadow[r];
        rd1_addr = r;
        rd2_addr = r;
        @(posedge clk);
        check_value(rd1_data, expected, "Core read port 1");
        check_value(rd2_data, expected, "Core read port 2");
        @(negedge clk);
    endtask

    task automatic check_all_regs();
        for (int i = 1; i < `REG_NUM; i++) begin
            core_read_check(reg_addr_t'(i));
        end
    endtask

    // Debug write racing a core write held for busy_cycles
    task automatic debug_write_vs_core(input reg_addr_t dbg_reg, input reg_addr_t core_reg,
                                       input int busy_cycles, input logic expect_err);
        cpu_word_t dbg_data;
        cpu_word_t core_data;
        logic      err;
        dbg_data  = random_bits(32);
        core_data = random_bits(32);
        fork
            apb_write(apb_addr_t'({dbg_reg, 2'b00}), dbg_data, err);
            begin
                // First access cycle starts at the next falling edge
                @(negedge clk);
                wb_req = '{en: 1'b1, addr: core_reg, data: core_data};
                repeat (busy_cycles) @(negedge clk);
                wb_req.en        = 1'b0;
                shadow[core_reg] = core_data;
                rd1_addr         = core_reg;
                @(posedge clk);
                check_value(rd1_data, core_data, "Core value before deferred debug write");
                @(negedge clk);
            end
        join
        check_value(cpu_word_t'(err), cpu_word_t'(expect_err), "PSLVERR after stalled write");
        if (!expect_err) begin
            shadow[dbg_reg] = dbg_data;
        end
        core_read_check(dbg_reg);
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_core_ports();
        reg_addr_t r;
        for (int i = 1; i < `REG_NUM; i++) begin
            core_write(reg_addr_t'(i), random_bits(32));
            core_read_check(reg_addr_t'(i));
        end
        repeat (8) begin
            r = random_reg();
            core_write(r, random_bits(32));
            core_read_check(r);
        end
        core_write('0, random_bits(32));
        core_read_check('0);
    endtask

    task automatic test_debug_access();
        reg_addr_t r;
        cpu_word_t data;
        logic      err;
        repeat (8) begin
            r = random_reg();
            debug_write_ok(r, random_bits(32));
            apb_read(apb_addr_t'({r, 2'b00}), data, err);
            check_value(cpu_word_t'(err), '0, "PSLVERR on debug read");
            check_value(data, shadow[r], "Debug read data");
            core_read_check(r);
        end
        // x0 over APB
        debug_write_ok('0, random_bits(32));
        apb_read('0, data, err);
        check_value(cpu_word_t'(err), '0, "PSLVERR on x0 read");
        check_value(data, '0, "Debug read of x0");
    endtask

    task automatic test_write_arbitration();
        reg_addr_t r;
        reg_addr_t other;
        r     = random_reg();
        other = (r == reg_addr_t'(31)) ? reg_addr_t'(1) : r + 1'b1;
        debug_write_vs_core(r, r, 1, 1'b0);
        debug_write_vs_core(r, other, `DBG_WAIT_LIMIT - 6, 1'b0);
        debug_write_vs_core(r, other, 2 * `DBG_WAIT_LIMIT, 1'b1);
    endtask

    task automatic test_illegal_addr();
        apb_addr_t bad_addr [4];
        cpu_word_t data;
        logic      err;
        bad_addr = '{12'h002, 12'h041, 12'h080, 12'hFFC};
        foreach (bad_addr[i]) begin
            apb_write(bad_addr[i], random_bits(32), err);
            check_value(cpu_word_t'(err), 32'd1, "PSLVERR on illegal write");
            apb_read(bad_addr[i], data, err);
            check_value(cpu_word_t'(err), 32'd1, "PSLVERR on illegal read");
            check_value(data, '0, "Illegal read data");
        end
        check_all_regs();
    endtask

    task automatic test_status_pins();
        repeat (2) begin
            core_write(reg_addr_t'(26), random_bits(32));
            check_status();
            debug_write_ok(reg_addr_t'(27), random_bits(32));
            check_status();
            core_write(reg_addr_t'(27), random_bits(32));
            check_status();
            debug_write_ok(reg_addr_t'(26), random_bits(32));
            check_status();
        end
    endtask

    initial begin
        int waited;
        wb_req   = '0;
        rd1_addr = reg_addr_t'(5);
        rd2_addr = '0;
        // Access phase held in reset must not complete
        apb_req  = '{psel: 1'b1, penable: 1'b1, pwrite: 1'b1, paddr: '0, pwdata: '0};
        repeat (2) @(posedge clk);
        check_value(rd1_data, '0, "Read port during reset");
        check_value(cpu_word_t'(apb_rsp.pready), '0, "PREADY during reset");
        @(negedge clk);
        apb_req = '0;
        waited = 0;
        while (!rst_n) begin
            waited++;
            if (waited > 10) begin
                abort_run("Reset was never released");
            end
            @(posedge clk);
        end
        @(negedge clk);
        test_core_ports();
        test_debug_access();
        test_write_arbitration();
        test_illegal_addr();
        test_status_pins();
        if (error_count == 0 &&
            regfile_subsys_top_i.regfile_subsys_checker_i.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== test/regfile_subsys_checker.sv ====
/*
 * Register file subsystem assertions
 * APB handshake, stall bound and x0 read rules for the top level
 */

`timescale 1ns/1ns

`include "regfile_params.svh"

module regfile_subsys_checker (
    input logic                   clk,
    input logic                   rst_n,
    input regfile_pkg::apb_req_t  apb_req_i,
    input regfile_pkg::apb_rsp_t  apb_rsp_o,
    input logic                   timer_run_i,
    input regfile_pkg::reg_addr_t rd1_addr_i,
    input regfile_pkg::cpu_word_t rd1_data_o
);

    import regfile_pkg::*;

    logic in_setup;
    logic in_wait;

    // Assertion failures so far
    int unsigned fail_count = 0;

    // --------------------
    // APB phases
    // --------------------
    assign in_setup = apb_req_i.psel && !apb_req_i.penable;
    assign in_wait  = apb_req_i.psel && apb_req_i.penable && !apb_rsp_o.pready;

    // No completion in the setup phase
    setup_no_ready: assert property (@(posedge clk) disable iff (!rst_n)
        in_setup |-> !apb_rsp_o.pready)
        else begin
            $error("PREADY high in APB setup phase");
            fail_count++;
        end

    // Host holds the request while the slave waits
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        in_wait |=> $stable(apb_req_i))
        else begin
            $error("APB request changed while PREADY was low");
            fail_count++;
        end

    // Stall bounded by the wait timer
    stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(timer_run_i) |-> ##[1:`DBG_WAIT_LIMIT + 1] !timer_run_i)
        else begin
            $error("Debug write stall outlived the wait limit");
            fail_count++;
        end

    // x0 always reads zero
    x0_reads_zero: assert property (@(posedge clk)
        (rd1_addr_i == '0) |-> (rd1_data_o == '0))
        else begin
            $error("Read port 1 returned nonzero data for x0");
            fail_count++;
        end

endmodule

bind regfile_subsys_top regfile_subsys_checker regfile_subsys_checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .timer_run_i (timer_run),
    .rd1_addr_i  (rd1_addr_i),
    .rd1_data_o  (rd1_data_o)
);

// ==== test/tb_clkgen.sv ====
/*
 * Testbench clock and reset
 * 100 ns clock, active-low reset held for four cycles
 */

`timescale 1ns/1ns

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the flops
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== verilog/regfile_subsys_top.sv ====
/*
 * Register file subsystem top
 * Register file with an APB debug port and its write wait timer
 */

`timescale 1ns/1ns

module regfile_subsys_top (
    input  logic                     clk,
    input  logic                     rst_n,

    // Core side
    input  regfile_pkg::reg_wr_req_t wb_req_i,
    input  regfile_pkg::reg_addr_t   rd1_addr_i,
    output regfile_pkg::cpu_word_t   rd1_data_o,
    input  regfile_pkg::reg_addr_t   rd2_addr_i,
    output regfile_pkg::cpu_word_t   rd2_data_o,

    // Debug host, APB
    input  regfile_pkg::apb_req_t    apb_req_i,
    output regfile_pkg::apb_rsp_t    apb_rsp_o,

    // x27[0], x26[0]
    output logic [1:0]               status_o
);

    import regfile_pkg::*;

    // --------------------
    // Internal wires
    // --------------------
    reg_wr_req_t dbg_wr_req;
    reg_addr_t   dbg_rd_addr;
    cpu_word_t   dbg_rd_data;
    logic        timer_start;
    logic        timer_run;
    logic        timer_expired;
    // Core write-back blocks debug writes
    logic        core_wr_busy;

    assign core_wr_busy = wb_req_i.en;

    // Storage and read ports
    rv_regfile rv_regfile_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb_req_i      (wb_req_i),
        .dbg_wr_req_i  (dbg_wr_req),
        .rd1_addr_i    (rd1_addr_i),
        .rd1_data_o    (rd1_data_o),
        .rd2_addr_i    (rd2_addr_i),
        .rd2_data_o    (rd2_data_o),
        .dbg_rd_addr_i (dbg_rd_addr),
        .dbg_rd_data_o (dbg_rd_data),
        .status_o      (status_o)
    );

    // APB slave
    dbg_apb_fsm dbg_apb_fsm_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .apb_req_i       (apb_req_i),
        .apb_rsp_o       (apb_rsp_o),
        .core_wr_busy_i  (core_wr_busy),
        .dbg_wr_req_o    (dbg_wr_req),
        .dbg_rd_addr_o   (dbg_rd_addr),
        .dbg_rd_data_i   (dbg_rd_data),
        .timer_start_o   (timer_start),
        .timer_run_o     (timer_run),
        .timer_expired_i (timer_expired)
    );

    // Stall bound
    dbg_wait_timer dbg_wait_timer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (timer_start),
        .run_i     (timer_run),
        .expired_o (timer_expired)
    );

endmodule

// ==== verilog/dbg_apb_fsm.sv ====
/*
 * Debug APB slave for the register file
 * Decodes PADDR to a register index, defers writes to core write-back,
 * and forms PREADY / PSLVERR including wait timer expiry
 */

`timescale 1ns/1ns

`include "regfile_params.svh"

module dbg_apb_fsm (
    input  logic                     clk,
    input  logic                     rst_n,

    // APB slave side
    input  regfile_pkg::apb_req_t    apb_req_i,
    output regfile_pkg::apb_rsp_t    apb_rsp_o,

    // Core write-back active this cycle
    input  logic                     core_wr_busy_i,

    // Register file side
    output regfile_pkg::reg_wr_req_t dbg_wr_req_o,
    output regfile_pkg::reg_addr_t   dbg_rd_addr_o,
    input  regfile_pkg::cpu_word_t   dbg_rd_data_i,

    // Wait timer control
    output logic                     timer_start_o,
    output logic                     timer_run_o,
    input  logic                     timer_expired_i
);

    import regfile_pkg::*;

    dbg_state_t state_q;
    dbg_state_t state_d;

    reg_addr_t  reg_idx;
    logic       addr_legal;
    logic       in_setup;
    logic       in_access;
    logic       wr_grant;

    // --------------------
    // Address decode
    // --------------------
    // Word index from bits 6:2
    assign reg_idx = apb_req_i.paddr[`REG_ADDR_WIDTH+1:2];

    // Upper bits and byte offset must be zero
    assign addr_legal = (apb_req_i.paddr[`APB_ADDR_WIDTH-1:`REG_ADDR_WIDTH+2] == '0) &&
                        (apb_req_i.paddr[1:0] == 2'b00);

    // APB phases
    assign in_setup  = apb_req_i.psel && !apb_req_i.penable;
    assign in_access = apb_req_i.psel && apb_req_i.penable;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DBG_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Next state and response
    // --------------------
    always_comb begin
        state_d       = state_q;
        apb_rsp_o     = '0;
        wr_grant      = 1'b0;
        timer_start_o = 1'b0;

        case (state_q)
            DBG_IDLE: begin
                // Setup cycle seen, next cycle is the first access
                if (in_setup) begin
                    state_d = DBG_ACCESS;
                end
            end

            DBG_ACCESS: begin
                if (!in_access) begin
                    // Host dropped the transfer
                    state_d = DBG_IDLE;
                end else if (!addr_legal) begin
                    // Bad address, error at once, prdata stays zero
                    apb_rsp_o.pready  = 1'b1;
                    apb_rsp_o.pslverr = 1'b1;
                    state_d           = DBG_IDLE;
                end else if (!apb_req_i.pwrite) begin
                    // Reads never wait
                    apb_rsp_o.pready = 1'b1;
                    apb_rsp_o.prdata = dbg_rd_data_i;
                    state_d          = DBG_IDLE;
                end else if (!core_wr_busy_i) begin
                    // Write port free, write lands at this edge
                    apb_rsp_o.pready = 1'b1;
                    wr_grant         = 1'b1;
                    state_d          = DBG_IDLE;
                end else begin
                    // Core owns the write port, start waiting
                    timer_start_o = 1'b1;
                    state_d       = DBG_STALL;
                end
            end

            DBG_STALL: begin
                if (!in_access) begin
                    state_d = DBG_IDLE;
                end else if (!core_wr_busy_i) begin
                    // Retry succeeds on the first free cycle
                    apb_rsp_o.pready = 1'b1;
                    wr_grant         = 1'b1;
                    state_d          = DBG_IDLE;
                end else if (timer_expired_i) begin
                    // Gave up, nothing written
                    apb_rsp_o.pready  = 1'b1;
                    apb_rsp_o.pslverr = 1'b1;
                    state_d           = DBG_IDLE;
                end
            end

            default: begin
                state_d = DBG_IDLE;
            end
        endcase
    end

    // Timer counts only while stalled
    assign timer_run_o = (state_q == DBG_STALL);

    // --------------------
    // Register file requests
    // --------------------
    assign dbg_wr_req_o.en   = wr_grant;
    assign dbg_wr_req_o.addr = reg_idx;
    assign dbg_wr_req_o.data = apb_req_i.pwdata;

    assign dbg_rd_addr_o = reg_idx;

endmodule

// ==== verilog/dbg_wait_timer.sv ====
/*
 * Debug write wait timer
 * Down-counter bounding how long a debug write may stall behind the core
 */

`timescale 1ns/1ns

`include "regfile_params.svh"

module dbg_wait_timer (
    input  logic clk,
    input  logic rst_n,
    // Load at stall entry
    input  logic start_i,
    // High while the FSM is stalled
    input  logic run_i,
    output logic expired_o
);

    localparam int CNT_W = $clog2(`DBG_WAIT_LIMIT);

    // Cycles left before the stall gives up
    logic [CNT_W-1:0] count_q;

    // --------------------
    // Counter
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (start_i) begin
            // One stall cycle per count down to zero
            count_q <= CNT_W'(`DBG_WAIT_LIMIT - 1);
        end else if (run_i && (count_q != '0)) begin
            count_q <= count_q - 1'b1;
        end
        // Holds once the stall is left
    end

    // Last allowed stall cycle
    assign expired_o = run_i && (count_q == '0);

endmodule

// ==== regfile/rv_regfile.sv ====
/*
 * RV32I integer register file
 * 32 x 32-bit storage, two core read ports, one debug read port,
 * one write port with core priority over debug, status pins from x26/x27
 */

`timescale 1ns/1ns

`include "regfile_params.svh"

module rv_regfile (
    input  logic                     clk,
    input  logic                     rst_n,

    // Core write-back
    input  regfile_pkg::reg_wr_req_t wb_req_i,
    // Debug write, lower priority
    input  regfile_pkg::reg_wr_req_t dbg_wr_req_i,

    // Core read port 1
    input  regfile_pkg::reg_addr_t   rd1_addr_i,
    output regfile_pkg::cpu_word_t   rd1_data_o,

    // Core read port 2
    input  regfile_pkg::reg_addr_t   rd2_addr_i,
    output regfile_pkg::cpu_word_t   rd2_data_o,

    // Debug read port
    input  regfile_pkg::reg_addr_t   dbg_rd_addr_i,
    output regfile_pkg::cpu_word_t   dbg_rd_data_o,

    // Bit 0 is x26[0], bit 1 is x27[0]
    output logic [1:0]               status_o
);

    import regfile_pkg::*;

    // Register storage, x0 entry never written
    cpu_word_t regs [`REG_NUM];

    logic core_wr;
    logic dbg_wr;

    // --------------------
    // Write port
    // --------------------
    // Writes to x0 are dropped
    assign core_wr = wb_req_i.en && (wb_req_i.addr != '0);
    assign dbg_wr  = dbg_wr_req_i.en && (dbg_wr_req_i.addr != '0);

    // Core write-back wins over debug in the same cycle
    always_ff @(posedge clk) begin
        // Writes ignored while held in reset
        if (rst_n) begin
            if (core_wr) begin
                regs[wb_req_i.addr] <= wb_req_i.data;
            end else if (dbg_wr) begin
                regs[dbg_wr_req_i.addr] <= dbg_wr_req_i.data;
            end
        end
    end

    // --------------------
    // Read ports
    // --------------------
    // Shared read mux, zero for x0 and during reset
    function automatic cpu_word_t read_word(input reg_addr_t addr, input logic rst_ok);
        cpu_word_t word;
        if (!rst_ok || (addr == '0)) begin
            word = '0;
        end else begin
            word = regs[addr];
        end
        return word;
    endfunction

    // Combinational, no bypass of the current write
    always_comb begin
        rd1_data_o = read_word(rd1_addr_i, rst_n);
    end

    always_comb begin
        rd2_data_o = read_word(rd2_addr_i, rst_n);
    end

    // Debug port also zero in reset
    always_comb begin
        dbg_rd_data_o = read_word(dbg_rd_addr_i, rst_n);
    end

    // --------------------
    // Status pins
    // --------------------
    assign status_o = {regs[27][0], regs[26][0]};

endmodule

// ==== common/regfile_pkg.sv ====
/*
 * Register file subsystem types
 * Word and index types, write request, APB request and response, debug FSM states
 */

`include "regfile_params.svh"

package regfile_pkg;

    // --------------------
    // Plain vector types
    // --------------------
    // Register index
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    // Data word
    typedef logic [`CPU_WIDTH-1:0]      cpu_word_t;
    // APB byte address
    typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;

    // --------------------
    // Bundles
    // --------------------
    // Write request, core write-back and debug write share it
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        cpu_word_t data;
    } reg_wr_req_t;

    // APB request from the debug host
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        cpu_word_t pwdata;
    } apb_req_t;

    // APB response, fields valid only with pready
    typedef struct packed {
        logic      pready;
        logic      pslverr;
        cpu_word_t prdata;
    } apb_rsp_t;

    // Debug APB slave states
    typedef enum logic [1:0] {
        DBG_IDLE   = 2'd0,
        DBG_ACCESS = 2'd1,
        DBG_STALL  = 2'd2
    } dbg_state_t;

endpackage

// ==== common/regfile_params.svh ====
/*
 * Register file subsystem parameters
 * Widths, register count and debug wait limit shared by all blocks
 */

`ifndef REGFILE_PARAMS_SVH
`define REGFILE_PARAMS_SVH

// --------------------
// Register file geometry
// --------------------
// Register index width, x0 to x31
`define REG_ADDR_WIDTH 5
// Data word width
`define CPU_WIDTH 32
// Number of integer registers
`define REG_NUM 32

// --------------------
// Debug access port
// --------------------
// PADDR width, one word per register at 0x00 to 0x7C
`define APB_ADDR_WIDTH 12
// Max stalled cycles for a debug write
`define DBG_WAIT_LIMIT 16

`endif
